// File: pmp_csr_pkg.sv
package pmp_csr_pkg;

  localparam int PMP_MAX_REGIONS = 16;
  localparam int PMP_CFG_W       = 8;
  localparam int PMP_ADDR_W      = 32;
  localparam int CSR_ADDR_W      = 12;
  localparam int CSR_DATA_W      = 32;

  typedef logic [PMP_CFG_W-1:0]  pmp_cfg_t;
  typedef logic [PMP_ADDR_W-1:0] pmp_addr_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  // Field positions inside one cfg byte
  localparam int CFG_R_BIT    = 0;
  localparam int CFG_W_BIT    = 1;
  localparam int CFG_X_BIT    = 2;
  localparam int CFG_MODE_LSB = 3;
  localparam int CFG_RSVD_LSB = 5;
  localparam int CFG_L_BIT    = 7;

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
  localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
  localparam csr_addr_t CSR_MSECCFG     = 12'h747;
  localparam int        MSECCFG_RLB_BIT = 2;

  function automatic pmp_mode_e cfg_mode(pmp_cfg_t cfg);
    return pmp_mode_e'(cfg[CFG_MODE_LSB +: 2]);
  endfunction

endpackage

// File: pmp_access_pkg.sv
package pmp_access_pkg;

  typedef logic [31:0] phys_addr_t;
  typedef logic [5:0]  exc_cause_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'd0,
    PMP_ACC_READ  = 2'd1,
    PMP_ACC_WRITE = 2'd2
  } pmp_acc_e;

  localparam exc_cause_t EXC_INSTR_ACC_FAULT = 6'd1;
  localparam exc_cause_t EXC_LOAD_ACC_FAULT  = 6'd5;
  localparam exc_cause_t EXC_STORE_ACC_FAULT = 6'd7;

endpackage

// File: pmp_csr_file.sv
`timescale 1ns/10ps

module pmp_csr_file
  import pmp_csr_pkg::*;
#(
  parameter int PMP_NUM_REGIONS = 8,
  parameter int PMP_GRANULARITY = 0
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            csr_we_i,
  input  csr_addr_t                       csr_addr_i,
  input  csr_data_t                       csr_wdata_i,
  output csr_data_t                       csr_rdata_o,
  output pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg_o,
  output pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_o
);

  localparam int NUM_CFG_WORDS = PMP_MAX_REGIONS / 4;
  // Low pmpaddr bits that the read-back view forces
  localparam int        NAPOT_ONES_W      = (PMP_GRANULARITY > 0) ? PMP_GRANULARITY - 1 : 0;
  localparam pmp_addr_t NAPOT_ONES_MASK   = pmp_addr_t'((64'd1 << NAPOT_ONES_W) - 64'd1);
  localparam pmp_addr_t OFF_TOR_ZERO_MASK = pmp_addr_t'((64'd1 << PMP_GRANULARITY) - 64'd1);

  pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg_q;
  pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg_d;
  pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_q;
  pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_d;
  pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_view;
  logic      [PMP_NUM_REGIONS-1:0] addr_locked;
  csr_data_t [NUM_CFG_WORDS-1:0]   cfg_word;
  logic                            rlb_q;

  function automatic pmp_cfg_t legalise_cfg(pmp_cfg_t old_cfg, pmp_cfg_t new_cfg, logic rlb);
    pmp_cfg_t res;
    res = new_cfg;
    // W without R keeps the old RWX
    if (new_cfg[CFG_W_BIT] && !new_cfg[CFG_R_BIT]) begin
      res[CFG_X_BIT:CFG_R_BIT] = old_cfg[CFG_X_BIT:CFG_R_BIT];
    end
    // No NA4 once the grain is 8 bytes or more
    if ((PMP_GRANULARITY >= 1) && (cfg_mode(new_cfg) == PMP_MODE_NA4)) begin
      res[CFG_MODE_LSB +: 2] = old_cfg[CFG_MODE_LSB +: 2];
    end
    if (old_cfg[CFG_L_BIT] && !rlb) begin
      res = old_cfg;
    end
    res[CFG_RSVD_LSB +: 2] = 2'b00;
    return res;
  endfunction

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : gen_region
    logic tor_above_locked;

    // Entry i is the base of a TOR entry i+1
    if (i < PMP_NUM_REGIONS - 1) begin : gen_above
      assign tor_above_locked = cfg_q[i+1][CFG_L_BIT] &&
                                (cfg_mode(cfg_q[i+1]) == PMP_MODE_TOR);
    end else begin : gen_top
      assign tor_above_locked = 1'b0;
    end

    assign addr_locked[i] = !rlb_q && (cfg_q[i][CFG_L_BIT] || tor_above_locked);

    assign addr_view[i] = (cfg_mode(cfg_q[i]) == PMP_MODE_NAPOT) ? (addr_q[i] | NAPOT_ONES_MASK) :
                          cfg_q[i][CFG_MODE_LSB+1]              ? addr_q[i] :
                                                                  (addr_q[i] & ~OFF_TOR_ZERO_MASK);

    a_locked_cfg_frozen: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cfg_q[i][CFG_L_BIT] && !rlb_q |=> $stable(cfg_q[i])
    );
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (csr_we_i && (csr_addr_i == CSR_PMPCFG0 + csr_addr_t'(i / 4))) begin
        cfg_d[i] = legalise_cfg(cfg_q[i], csr_wdata_i[8*(i%4) +: 8], rlb_q);
      end
      if (csr_we_i && (csr_addr_i == CSR_PMPADDR0 + csr_addr_t'(i)) && !addr_locked[i]) begin
        addr_d[i] = csr_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
      if (csr_we_i && (csr_addr_i == CSR_MSECCFG)) begin
        rlb_q <= csr_wdata_i[MSECCFG_RLB_BIT];
      end
    end
  end

  // Pack the cfg bytes into words, missing regions stay zero
  always_comb begin
    cfg_word = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      cfg_word[i/4][8*(i%4) +: 8] = cfg_q[i];
    end
  end

  always_comb begin
    csr_rdata_o = '0;
    for (int w = 0; w < NUM_CFG_WORDS; w++) begin
      if (csr_addr_i == CSR_PMPCFG0 + csr_addr_t'(w)) begin
        csr_rdata_o = cfg_word[w];
      end
    end
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (csr_addr_i == CSR_PMPADDR0 + csr_addr_t'(i)) begin
        csr_rdata_o = addr_view[i];
      end
    end
    if (csr_addr_i == CSR_MSECCFG) begin
      csr_rdata_o[MSECCFG_RLB_BIT] = rlb_q;
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

endmodule

// File: pmp_region_match.sv
`timescale 1ns/10ps

module pmp_region_match
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
#(
  parameter int PMP_NUM_REGIONS = 8,
  parameter int PMP_GRANULARITY = 0
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg_i,
  input  pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_i,
  input  logic                            req_valid_i,
  input  phys_addr_t                      req_addr_i,
  input  pmp_acc_e                        req_acc_i,
  input  priv_lvl_e                       req_priv_i,
  output logic                            s1_valid_o,
  output logic      [PMP_NUM_REGIONS-1:0] s1_match_o,
  output logic      [PMP_NUM_REGIONS-1:0] s1_perm_o,
  output logic      [PMP_NUM_REGIONS-1:0] s1_lock_o,
  output pmp_acc_e                        s1_acc_o,
  output priv_lvl_e                       s1_priv_o
);

  logic [33:0]                req_byte_addr;
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic [PMP_NUM_REGIONS-1:0] region_perm;
  logic [PMP_NUM_REGIONS-1:0] region_lock;

  assign req_byte_addr = {2'b00, req_addr_i};

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : gen_region
    logic [33:0] lo_addr;
    logic [33:0] hi_addr;
    pmp_addr_t   napot_mask;
    logic        hit;
    logic        perm;

    if (i == 0) begin : gen_base
      assign lo_addr = '0;
    end else begin : gen_prev
      assign lo_addr = {addr_i[i-1], 2'b00};
    end
    assign hi_addr = {addr_i[i], 2'b00};

    // Drops the trailing ones and the lowest clear bit
    assign napot_mask = ~(addr_i[i] ^ (addr_i[i] + 32'd1));

    always_comb begin
      case (cfg_mode(cfg_i[i]))
        PMP_MODE_TOR:   hit = (req_byte_addr >= lo_addr) && (req_byte_addr < hi_addr);
        PMP_MODE_NA4:   hit = (req_byte_addr[33:2] == addr_i[i]);
        PMP_MODE_NAPOT: hit = ((req_byte_addr[33:2] ^ addr_i[i]) & napot_mask) == '0;
        default:        hit = 1'b0;
      endcase
    end

    always_comb begin
      case (req_acc_i)
        PMP_ACC_EXEC:  perm = cfg_i[i][CFG_X_BIT];
        PMP_ACC_READ:  perm = cfg_i[i][CFG_R_BIT];
        PMP_ACC_WRITE: perm = cfg_i[i][CFG_W_BIT];
        default:       perm = 1'b0;
      endcase
    end

    assign region_match[i] = hit;
    assign region_perm[i]  = perm;
    assign region_lock[i]  = cfg_i[i][CFG_L_BIT];

    a_off_never_matches: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (cfg_mode(cfg_i[i]) == PMP_MODE_OFF) |=> !s1_match_o[i]
    );

    // The CSR file must never let NA4 through at this grain
    if (PMP_GRANULARITY >= 1) begin : gen_no_na4
      a_no_na4_mode: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cfg_mode(cfg_i[i]) != PMP_MODE_NA4
      );
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= req_valid_i;
    end
  end

  // Stage 1 payload
  always_ff @(posedge clk_i) begin
    s1_match_o <= region_match;
    s1_perm_o  <= region_perm;
    s1_lock_o  <= region_lock;
    s1_acc_o   <= req_acc_i;
    s1_priv_o  <= req_priv_i;
  end

endmodule

// File: pmp_decision.sv
`timescale 1ns/10ps

module pmp_decision
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
#(
  parameter int PMP_NUM_REGIONS = 8,
  parameter int PMP_GRANULARITY = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       s1_valid_i,
  input  logic [PMP_NUM_REGIONS-1:0] s1_match_i,
  input  logic [PMP_NUM_REGIONS-1:0] s1_perm_i,
  input  logic [PMP_NUM_REGIONS-1:0] s1_lock_i,
  input  pmp_acc_e                   s1_acc_i,
  input  priv_lvl_e                  s1_priv_i,
  output logic                       resp_valid_o,
  output logic                       resp_allow_o,
  output exc_cause_t                 resp_cause_o
);

  logic       hit;
  logic       hit_perm;
  logic       hit_lock;
  logic       allow;
  exc_cause_t fault_cause;

  if ((PMP_NUM_REGIONS < 4) || (PMP_NUM_REGIONS > PMP_MAX_REGIONS) ||
      (PMP_NUM_REGIONS % 4 != 0)) begin : gen_bad_regions
    $error("PMP_NUM_REGIONS must be 4, 8, 12 or 16");
  end
  if ((PMP_GRANULARITY < 0) || (PMP_GRANULARITY > 8)) begin : gen_bad_granularity
    $error("PMP_GRANULARITY must be between 0 and 8");
  end

  // Scan downwards so the lowest matching region wins
  always_comb begin
    hit      = 1'b0;
    hit_perm = 1'b0;
    hit_lock = 1'b0;
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (s1_match_i[i]) begin
        hit      = 1'b1;
        hit_perm = s1_perm_i[i];
        hit_lock = s1_lock_i[i];
      end
    end
  end

  // M-mode is only bound by locked regions
  always_comb begin
    if (s1_priv_i == PRIV_LVL_M) begin
      allow = !hit || !hit_lock || hit_perm;
    end else begin
      allow = hit && hit_perm;
    end
  end

  always_comb begin
    case (s1_acc_i)
      PMP_ACC_EXEC:  fault_cause = EXC_INSTR_ACC_FAULT;
      PMP_ACC_WRITE: fault_cause = EXC_STORE_ACC_FAULT;
      default:       fault_cause = EXC_LOAD_ACC_FAULT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
      resp_allow_o <= 1'b0;
      resp_cause_o <= '0;
    end else begin
      resp_valid_o <= s1_valid_i;
      resp_allow_o <= s1_valid_i && allow;
      resp_cause_o <= (s1_valid_i && !allow) ? fault_cause : '0;
    end
  end

  a_cause_iff_denied: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (resp_cause_o != '0) == (resp_valid_o && !resp_allow_o)
  );

  a_no_allow_when_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !resp_valid_o |-> !resp_allow_o
  );

endmodule

// File: pmp_checker.sv
`timescale 1ns/10ps

module pmp_checker
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
#(
  parameter int PMP_NUM_REGIONS = 8,
  parameter int PMP_GRANULARITY = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // CSR port
  input  logic       csr_we_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_data_t  csr_wdata_i,
  output csr_data_t  csr_rdata_o,
  // Access port
  input  logic       req_valid_i,
  input  phys_addr_t req_addr_i,
  input  pmp_acc_e   req_acc_i,
  input  priv_lvl_e  req_priv_i,
  output logic       resp_valid_o,
  output logic       resp_allow_o,
  output exc_cause_t resp_cause_o
);

  pmp_cfg_t  [PMP_NUM_REGIONS-1:0] cfg_q;
  pmp_addr_t [PMP_NUM_REGIONS-1:0] addr_q;

  // Stage 1 results
  logic                            s1_valid;
  logic      [PMP_NUM_REGIONS-1:0] s1_match;
  logic      [PMP_NUM_REGIONS-1:0] s1_perm;
  logic      [PMP_NUM_REGIONS-1:0] s1_lock;
  pmp_acc_e                        s1_acc;
  priv_lvl_e                       s1_priv;

  pmp_csr_file #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) u_csr_file (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg_q),
    .addr_o      (addr_q)
  );

  pmp_region_match #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) u_region_match (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_q),
    .addr_i      (addr_q),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_acc_i   (req_acc_i),
    .req_priv_i  (req_priv_i),
    .s1_valid_o  (s1_valid),
    .s1_match_o  (s1_match),
    .s1_perm_o   (s1_perm),
    .s1_lock_o   (s1_lock),
    .s1_acc_o    (s1_acc),
    .s1_priv_o   (s1_priv)
  );

  pmp_decision #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) u_decision (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s1_valid_i   (s1_valid),
    .s1_match_i   (s1_match),
    .s1_perm_i    (s1_perm),
    .s1_lock_i    (s1_lock),
    .s1_acc_i     (s1_acc),
    .s1_priv_i    (s1_priv),
    .resp_valid_o (resp_valid_o),
    .resp_allow_o (resp_allow_o),
    .resp_cause_o (resp_cause_o)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset releases on the edge that closes the reset window
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: pmp_scoreboard.sv
`timescale 1ns/10ps

module pmp_scoreboard
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
#(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       csr_we_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_data_t  csr_wdata_i,
  input  csr_data_t  csr_rdata_i,
  input  logic       req_valid_i,
  input  phys_addr_t req_addr_i,
  input  pmp_acc_e   req_acc_i,
  input  priv_lvl_e  req_priv_i,
  input  logic       resp_valid_i,
  input  logic       resp_allow_i,
  input  exc_cause_t resp_cause_i,
  output int         csr_errors_o,
  output int         resp_errors_o,
  output int         resp_checked_o
);

  // Register model
  pmp_cfg_t  cfg_m  [NUM_REGIONS];
  pmp_addr_t addr_m [NUM_REGIONS];
  logic      rlb_m;

  // Response pipeline, entry 1 is due at this edge
  logic       exp_valid [2];
  logic       exp_allow [2];
  exc_cause_t exp_cause [2];

  function automatic pmp_cfg_t next_cfg_byte(pmp_cfg_t old_cfg, pmp_cfg_t wr, logic rlb);
    pmp_cfg_t res;
    if (old_cfg[7] && !rlb) begin
      return old_cfg;
    end
    res      = wr;
    res[6:5] = 2'b00;
    if (wr[1] && !wr[0]) begin
      res[2:0] = old_cfg[2:0];
    end
    if ((GRANULARITY >= 1) && (wr[4:3] == PMP_MODE_NA4)) begin
      res[4:3] = old_cfg[4:3];
    end
    return res;
  endfunction

  function automatic logic addr_frozen(int i);
    logic frozen;
    frozen = cfg_m[i][7];
    // Base of a locked TOR entry above
    if (i + 1 < NUM_REGIONS) begin
      if (cfg_m[i+1][7] && (cfg_m[i+1][4:3] == PMP_MODE_TOR)) begin
        frozen = 1'b1;
      end
    end
    return frozen && !rlb_m;
  endfunction

  function automatic csr_data_t expected_read(csr_addr_t a);
    csr_data_t d;
    pmp_addr_t v;
    int        idx;
    d = '0;
    if ((a >= CSR_PMPCFG0) && (a < CSR_PMPCFG0 + 12'd4)) begin
      idx = int'(a - CSR_PMPCFG0);
      for (int b = 0; b < 4; b++) begin
        if (4 * idx + b < NUM_REGIONS) begin
          d[8*b +: 8] = cfg_m[4*idx + b];
        end
      end
    end else if ((a >= CSR_PMPADDR0) && (a < CSR_PMPADDR0 + csr_addr_t'(NUM_REGIONS))) begin
      idx = int'(a - CSR_PMPADDR0);
      v   = addr_m[idx];
      if (cfg_m[idx][4:3] == PMP_MODE_NAPOT) begin
        for (int b = 0; b < GRANULARITY - 1; b++) begin
          v[b] = 1'b1;
        end
      end else if (!cfg_m[idx][4]) begin
        // OFF and TOR hide the bits below the grain
        for (int b = 0; b < GRANULARITY; b++) begin
          v[b] = 1'b0;
        end
      end
      d = v;
    end else if (a == CSR_MSECCFG) begin
      d[MSECCFG_RLB_BIT] = rlb_m;
    end
    return d;
  endfunction

  function automatic logic region_hit(int i, phys_addr_t a);
    logic [33:0] byte_a;
    logic [33:0] lo;
    int          k;
    byte_a = {2'b00, a};
    lo     = '0;
    k      = 32;
    case (cfg_m[i][4:3])
      PMP_MODE_TOR: begin
        if (i > 0) begin
          lo = {addr_m[i-1], 2'b00};
        end
        return (byte_a >= lo) && (byte_a < {addr_m[i], 2'b00});
      end
      PMP_MODE_NA4: return byte_a[33:2] == addr_m[i];
      PMP_MODE_NAPOT: begin
        // Region of 2^(k+3) bytes where k is the lowest clear bit
        for (int b = 31; b >= 0; b--) begin
          if (!addr_m[i][b]) begin
            k = b;
          end
        end
        if (k == 32) begin
          return 1'b1;
        end
        return (byte_a >> (k + 3)) == ({2'b00, addr_m[i]} >> (k + 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  task automatic predict(input phys_addr_t a, input pmp_acc_e acc, input priv_lvl_e priv,
                         output logic allow, output exc_cause_t cause);
    logic found;
    logic perm;
    logic locked;
    found  = 1'b0;
    perm   = 1'b0;
    locked = 1'b0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (!found && region_hit(i, a)) begin
        found  = 1'b1;
        locked = cfg_m[i][7];
        perm   = (acc == PMP_ACC_EXEC) ? cfg_m[i][2] :
                 (acc == PMP_ACC_READ) ? cfg_m[i][0] : cfg_m[i][1];
      end
    end
    if (priv == PRIV_LVL_M) begin
      allow = !found || !locked || perm;
    end else begin
      allow = found && perm;
    end
    cause = allow                  ? 6'd0 :
            (acc == PMP_ACC_EXEC)  ? EXC_INSTR_ACC_FAULT :
            (acc == PMP_ACC_WRITE) ? EXC_STORE_ACC_FAULT : EXC_LOAD_ACC_FAULT;
  endtask

  task automatic apply_write(input csr_addr_t a, input csr_data_t d);
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (a == CSR_PMPCFG0 + csr_addr_t'(i / 4)) begin
        cfg_m[i] = next_cfg_byte(cfg_m[i], d[8*(i%4) +: 8], rlb_m);
      end
      if ((a == CSR_PMPADDR0 + csr_addr_t'(i)) && !addr_frozen(i)) begin
        addr_m[i] = d;
      end
    end
    if (a == CSR_MSECCFG) begin
      rlb_m = d[MSECCFG_RLB_BIT];
    end
  endtask

  task automatic check_response();
    if (exp_valid[1] && !resp_valid_i) begin
      $display("%0t: A request accepted two cycles earlier got no response", $time);
      resp_errors_o++;
    end else if (!exp_valid[1] && resp_valid_i) begin
      $display("%0t: A response appeared with no request two cycles earlier", $time);
      resp_errors_o++;
    end else if (exp_valid[1]) begin
      resp_checked_o++;
      if (resp_allow_i !== exp_allow[1]) begin
        $display("Error [resp_allow] at %0t: expected %0b, actual %0b",
                 $time, exp_allow[1], resp_allow_i);
        resp_errors_o++;
      end
      if (resp_cause_i !== exp_cause[1]) begin
        $display("Error [resp_cause] at %0t: expected %0d, actual %0d",
                 $time, exp_cause[1], resp_cause_i);
        resp_errors_o++;
      end
    end
  endtask

  initial begin
    csr_errors_o   = 0;
    resp_errors_o  = 0;
    resp_checked_o = 0;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        cfg_m[i]  = '0;
        addr_m[i] = '0;
      end
      rlb_m        = 1'b0;
      exp_valid[0] = 1'b0;
      exp_valid[1] = 1'b0;
    end else begin
      if (csr_rdata_i !== expected_read(csr_addr_i)) begin
        $display("Error [csr_readback] addr 0x%03h: expected 0x%08h, actual 0x%08h",
                 csr_addr_i, expected_read(csr_addr_i), csr_rdata_i);
        csr_errors_o++;
      end
      check_response();
      exp_valid[1] = exp_valid[0];
      exp_allow[1] = exp_allow[0];
      exp_cause[1] = exp_cause[0];
      exp_valid[0] = req_valid_i;
      // Uses the registers as they stand before this edge's write
      predict(req_addr_i, req_acc_i, req_priv_i, exp_allow[0], exp_cause[0]);
      if (csr_we_i) begin
        apply_write(csr_addr_i, csr_wdata_i);
      end
    end
  end

endmodule

// File: tb_pmp_checker.sv
`timescale 1ns/10ps

module tb_pmp_checker
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
();

  localparam int NUM_REGIONS  = 8;
  localparam int GRANULARITY  = 2;
  localparam int PERIOD_NS    = 10;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_CYCLES   = 2000;
  localparam int QUIET_CYCLES = 16;
  localparam int SEED         = 20315;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * PERIOD_NS;

  logic       clk;
  logic       rst_n;
  logic       csr_we;
  csr_addr_t  csr_addr;
  csr_data_t  csr_wdata;
  csr_data_t  csr_rdata;
  logic       req_valid;
  phys_addr_t req_addr;
  pmp_acc_e   req_acc;
  priv_lvl_e  req_priv;
  logic       resp_valid;
  logic       resp_allow;
  exc_cause_t resp_cause;
  int         csr_errors;
  int         resp_errors;
  int         resp_checked;

  // Last pmpaddr values written, used to aim requests at region bounds
  pmp_addr_t addr_hist [NUM_REGIONS];

  tb_clock_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  pmp_checker #(
    .PMP_NUM_REGIONS (NUM_REGIONS),
    .PMP_GRANULARITY (GRANULARITY)
  ) dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_we_i     (csr_we),
    .csr_addr_i   (csr_addr),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata),
    .req_valid_i  (req_valid),
    .req_addr_i   (req_addr),
    .req_acc_i    (req_acc),
    .req_priv_i   (req_priv),
    .resp_valid_o (resp_valid),
    .resp_allow_o (resp_allow),
    .resp_cause_o (resp_cause)
  );

  pmp_scoreboard #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_scoreboard (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .csr_we_i       (csr_we),
    .csr_addr_i     (csr_addr),
    .csr_wdata_i    (csr_wdata),
    .csr_rdata_i    (csr_rdata),
    .req_valid_i    (req_valid),
    .req_addr_i     (req_addr),
    .req_acc_i      (req_acc),
    .req_priv_i     (req_priv),
    .resp_valid_i   (resp_valid),
    .resp_allow_i   (resp_allow),
    .resp_cause_i   (resp_cause),
    .csr_errors_o   (csr_errors),
    .resp_errors_o  (resp_errors),
    .resp_checked_o (resp_checked)
  );

  function automatic csr_addr_t pick_csr_addr();
    int unsigned r;
    r = $urandom % 100;
    if (r < 30) begin
      return CSR_PMPCFG0 + csr_addr_t'($urandom % 4);
    end else if (r < 80) begin
      return CSR_PMPADDR0 + csr_addr_t'($urandom % NUM_REGIONS);
    end else if (r < 86) begin
      return CSR_PMPADDR0 + csr_addr_t'($urandom % 16);
    end else if (r < 96) begin
      return CSR_MSECCFG;
    end
    return csr_addr_t'($urandom);
  endfunction

  function automatic pmp_cfg_t pick_cfg_byte();
    pmp_cfg_t b;
    b = pmp_cfg_t'($urandom);
    // Keep most regions unlocked
    if ($urandom % 4 != 0) begin
      b[7] = 1'b0;
    end
    return b;
  endfunction

  function automatic pmp_addr_t pick_pmpaddr();
    pmp_addr_t v;
    int unsigned ones;
    v    = $urandom;
    v    = v & (($urandom % 2 == 0) ? 32'h0000_fff0 : 32'h3fff_fff0);
    ones = $urandom % 8;
    return v | ((32'd1 << ones) - 32'd1);
  endfunction

  function automatic phys_addr_t pick_req_addr();
    pmp_addr_t bound;
    if ($urandom % 4 == 0) begin
      return $urandom;
    end
    bound = addr_hist[$urandom % NUM_REGIONS];
    return phys_addr_t'({bound, 2'b00}) + ($urandom % 64) - 32'd32;
  endfunction

  task automatic drive_cycle(input bit writes_on, input csr_addr_t a);
    csr_data_t d;
    d = $urandom;
    if (writes_on && ($urandom % 10 < 4)) begin
      if ((a >= CSR_PMPADDR0) && (a < CSR_PMPADDR0 + 12'd16)) begin
        d = pick_pmpaddr();
        if (a - CSR_PMPADDR0 < NUM_REGIONS) begin
          addr_hist[a - CSR_PMPADDR0] = d;
        end
      end else if ((a >= CSR_PMPCFG0) && (a < CSR_PMPCFG0 + 12'd4)) begin
        d = {pick_cfg_byte(), pick_cfg_byte(), pick_cfg_byte(), pick_cfg_byte()};
      end
      csr_we <= 1'b1;
    end else begin
      csr_we <= 1'b0;
    end
    csr_addr  <= a;
    csr_wdata <= d;
    req_valid <= ($urandom % 10 < 7);
    req_addr  <= pick_req_addr();
    req_acc   <= pmp_acc_e'(2'($urandom % 3));
    req_priv  <= ($urandom % 2 == 0) ? PRIV_LVL_M : PRIV_LVL_U;
  endtask

  initial begin
    csr_addr_t quiet_addr;
    bit        failed;
    void'($urandom(SEED));
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_acc   = PMP_ACC_READ;
    req_priv  = PRIV_LVL_M;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      addr_hist[i] = '0;
    end
    @(posedge rst_n);
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      if (c < QUIET_CYCLES) begin
        // Walk the reset values before any write
        quiet_addr = (c < 4)  ? CSR_PMPCFG0 + csr_addr_t'(c) :
                     (c < 12) ? CSR_PMPADDR0 + csr_addr_t'(c - 4) : CSR_MSECCFG;
        drive_cycle(1'b0, quiet_addr);
      end else begin
        drive_cycle(1'b1, pick_csr_addr());
      end
    end
    @(posedge clk);
    csr_we    <= 1'b0;
    req_valid <= 1'b0;
    repeat (4) @(posedge clk);
    failed = (csr_errors != 0) || (resp_errors != 0);
    if (resp_checked == 0) begin
      $display("No response was ever checked");
      failed = 1'b1;
    end
    $display("Errors: csr read-back %0d, response %0d (%0d responses checked)",
             csr_errors, resp_errors, resp_checked);
    if (!failed) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired: the run did not end within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: pmp_checker.f
pmp_csr_pkg.sv
pmp_access_pkg.sv
pmp_csr_file.sv
pmp_region_match.sv
pmp_decision.sv
pmp_checker.sv
tb_clock_gen.sv
pmp_scoreboard.sv
tb_pmp_checker.sv

// File: run.sh
#!/bin/sh
# Build and run the PMP checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_pmp_checker \
  -f pmp_checker.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pmp_checker)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
